// File: src/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // slice commands, the bit pattern is {carry_in, b_inv, carry_disable, mux_sel}
    typedef enum logic [4:0] {
        cmd_add   = 5'b00000, // also a left shift when a equals b
        cmd_sub   = 5'b11000, // a + ~b + 1, carry out set means no borrow
        cmd_xor   = 5'b00100,
        cmd_xnor  = 5'b01100, // gives not b when a is 0
        cmd_comp  = 5'b01000, // a - b - 1, carry out set means a > b when a != b
        cmd_and   = 5'b00101,
        cmd_or    = 5'b00110,
        cmd_rshft = 5'b00111  // b moves right by one, a is ignored
    } alu_cmd_e;

    typedef struct packed {
        logic       carry_in;      // carry into the lowest bit
        logic       b_inv;         // second operand is inverted
        logic       carry_disable; // carry is kept out of the result
        logic [1:0] mux_sel;       // logic function picked in each bit cell
    } alu_ctrl_bits_t;

    typedef union packed {
        alu_cmd_e       cmd;
        alu_ctrl_bits_t bits;
    } alu_ctrl_t;

    // opcodes accepted on the request stream
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_adc  = 4'd1,
        op_sub  = 4'd2,
        op_sbc  = 4'd3,
        op_cmp  = 4'd4,
        op_and  = 4'd5,
        op_or   = 4'd6,
        op_xor  = 4'd7,
        op_xnor = 4'd8,
        op_shr  = 4'd9,
        op_rrc  = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

endpackage

`default_nettype wire

// File: src/alu_bit_cell.sv
`default_nettype none

module alu_bit_cell (
    input  logic                     a,
    input  logic                     b,
    input  logic                     carry_in,
    input  logic                     direct_in, // passed straight to res in shift mode
    input  alu_pkg::alu_ctrl_bits_t  ctrl,
    output logic                     res,
    output logic                     gen,
    output logic                     prop,
    output logic                     b_eff
);

    logic carry;
    logic func;

    assign b_eff = b ^ ctrl.b_inv;                   // b as the adder sees it
    assign carry = carry_in & ~ctrl.carry_disable;

    assign gen  = a & b_eff;
    assign prop = a | b_eff;

    // gen and prop already carry and, or and xor, so one small mux covers all functions
    always_comb begin
        case (ctrl.mux_sel)
            2'b00:   func = ~gen & prop;  // a xor b_eff
            2'b01:   func = gen;
            2'b10:   func = prop;
            default: func = direct_in;
        endcase
    end

    assign res = func ^ carry;

endmodule

`default_nettype wire

// File: src/alu_slice.sv
`default_nettype none

module alu_slice (
    input  logic               [3:0] a,
    input  logic               [3:0] b,
    input  alu_pkg::alu_ctrl_t       ctrl,
    input  logic                     carry_in,  // also the fill bit in shift mode
    output logic               [3:0] res,
    output logic                     carry_out
);

    logic [3:0] gen;
    logic [3:0] prop;
    logic [4:0] b_eff;  // bit 4 is the bit entering from the left
    logic [4:0] c;

    assign b_eff[4] = carry_in;
    assign c[0]     = carry_in;

    for (genvar i = 0; i < 4; i++) begin : g_cell
        alu_bit_cell u_cell (
            .a         (a[i]),
            .b         (b[i]),
            .carry_in  (c[i]),
            .direct_in (b_eff[i+1]),
            .ctrl      (ctrl.bits),
            .res       (res[i]),
            .gen       (gen[i]),
            .prop      (prop[i]),
            .b_eff     (b_eff[i])
        );
    end

    // every carry is two gate levels from gen and prop, nothing ripples inside the slice
    assign c[1] = gen[0] | (c[0] & prop[0]);

    assign c[2] = gen[1]
                | (gen[0] & prop[1])
                | (c[0] & prop[0] & prop[1]);

    assign c[3] = gen[2]
                | (gen[1] & prop[2])
                | (gen[0] & prop[1] & prop[2])
                | (c[0] & prop[0] & prop[1] & prop[2]);

    assign c[4] = gen[3]
                | (gen[2] & prop[3])
                | (gen[1] & prop[2] & prop[3])
                | (gen[0] & prop[1] & prop[2] & prop[3])
                | (c[0] & prop[0] & prop[1] & prop[2] & prop[3]);

    assign carry_out = c[4];

endmodule

`default_nettype wire

// File: src/alu_word.sv
`default_nettype none

module alu_word #(
    parameter int WIDTH = 16  // must be a multiple of 4
) (
    input  logic               [WIDTH-1:0] a,
    input  logic               [WIDTH-1:0] b,
    input  alu_pkg::alu_ctrl_t             ctrl,
    input  logic                           carry_in,
    input  logic                           fill,   // bit shifted in at the top
    output logic               [WIDTH-1:0] result,
    output alu_pkg::alu_flags_t            flags
);

    import alu_pkg::*;

    localparam int NUM_SLICES = WIDTH / 4;

    logic is_shift;
    logic top_carry;

    assign is_shift = (ctrl.cmd == cmd_rshft);

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        logic arith_cin;
        logic shift_cin;
        logic cin;
        logic cout;

        if (i == 0) begin : g_first
            assign arith_cin = carry_in;
        end else begin : g_next
            assign arith_cin = g_slice[i-1].cout;  // carry ripples between slices
        end

        if (i == NUM_SLICES - 1) begin : g_top
            assign shift_cin = fill;
        end else begin : g_below
            assign shift_cin = b[4*i+4];           // lowest b bit of the slice above
        end

        assign cin = is_shift ? shift_cin : arith_cin;

        alu_slice u_slice (
            .a         (a[4*i+3 -: 4]),
            .b         (b[4*i+3 -: 4]),
            .ctrl      (ctrl),
            .carry_in  (cin),
            .res       (result[4*i+3 -: 4]),
            .carry_out (cout)
        );
    end

    assign top_carry = g_slice[NUM_SLICES-1].cout;

    // logic ops get the old carry on carry_in and hand it back unchanged
    always_comb begin
        if (is_shift) begin
            flags.carry = b[0];  // bit shifted out at the bottom
        end else if (ctrl.bits.carry_disable) begin
            flags.carry = carry_in;
        end else begin
            flags.carry = top_carry;
        end
        flags.zero = (result == '0);
    end

endmodule

`default_nettype wire

// File: src/alu_op_decode.sv
`default_nettype none

module alu_op_decode (
    input  alu_pkg::alu_op_e   op,
    input  logic               carry_flag,   // stored carry from earlier requests
    output alu_pkg::alu_ctrl_t ctrl,
    output logic               carry_in,
    output logic               fill,
    output logic               carry_update
);

    import alu_pkg::*;

    logic use_stored;  // carry_in comes from the stored carry

    always_comb begin
        ctrl.cmd     = cmd_add;
        use_stored   = 1'b0;
        fill         = 1'b0;
        carry_update = 1'b1;
        case (op)
            op_add: ctrl.cmd = cmd_add;
            op_adc: begin
                ctrl.cmd   = cmd_add;
                use_stored = 1'b1;
            end
            op_sub: ctrl.cmd = cmd_sub;
            op_sbc: begin
                ctrl.cmd   = cmd_sub;
                use_stored = 1'b1;                   // stored carry 0 means borrow one
            end
            op_cmp: ctrl.cmd = cmd_comp;
            op_and, op_or, op_xor, op_xnor: begin
                case (op)
                    op_and:  ctrl.cmd = cmd_and;
                    op_or:   ctrl.cmd = cmd_or;
                    op_xor:  ctrl.cmd = cmd_xor;
                    default: ctrl.cmd = cmd_xnor;
                endcase
                use_stored   = 1'b1;                 // word passes it back as the carry flag
                carry_update = 1'b0;
            end
            op_shr: ctrl.cmd = cmd_rshft;
            op_rrc: begin
                ctrl.cmd = cmd_rshft;
                fill     = carry_flag;               // rotate through the carry
            end
            default: carry_update = 1'b0;            // unused codes add but keep the carry
        endcase
        carry_in = use_stored ? carry_flag : ctrl.bits.carry_in;
    end

endmodule

`default_nettype wire

// File: src/alu_flag_reg.sv
`default_nettype none

module alu_flag_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,          // a request is accepted this cycle
    input  logic                carry_update,
    input  alu_pkg::alu_flags_t new_flags,
    output alu_pkg::alu_flags_t flags
);

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (load) begin
            flags.zero <= new_flags.zero;
            if (carry_update) begin
                flags.carry <= new_flags.carry;  // logic ops keep the old carry
            end
        end
    end

endmodule

`default_nettype wire

// File: src/alu_out_stage.sv
`default_nettype none

module alu_out_stage #(
    parameter int WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic                [WIDTH-1:0] result,
    input  alu_pkg::alu_flags_t             flags,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                [WIDTH-1:0] out_result,
    output alu_pkg::alu_flags_t             out_flags,
    output logic                            accept      // tells the flag register to load
);

    // a new request may enter when the slot is empty or drains this cycle
    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_result <= result;
            out_flags  <= flags;
        end
    end

endmodule

`default_nettype wire

// File: src/alu_unit.sv
`default_nettype none

module alu_unit #(
    parameter int WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  alu_pkg::alu_op_e                in_op,
    input  logic                [WIDTH-1:0] in_a,
    input  logic                [WIDTH-1:0] in_b,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                [WIDTH-1:0] out_result,
    output alu_pkg::alu_flags_t             out_flags
);

    import alu_pkg::*;

    alu_ctrl_t        ctrl;
    logic             carry_in;
    logic             fill;
    logic             carry_update;
    logic [WIDTH-1:0] result;
    alu_flags_t       new_flags;
    alu_flags_t       stored_flags;  // flags seen by the next request
    logic             accept;

    alu_op_decode u_decode (
        .op           (in_op),
        .carry_flag   (stored_flags.carry),
        .ctrl         (ctrl),
        .carry_in     (carry_in),
        .fill         (fill),
        .carry_update (carry_update)
    );

    alu_word #(
        .WIDTH (WIDTH)
    ) u_word (
        .a        (in_a),
        .b        (in_b),
        .ctrl     (ctrl),
        .carry_in (carry_in),
        .fill     (fill),
        .result   (result),
        .flags    (new_flags)
    );

    alu_flag_reg u_flags (
        .clk          (clk),
        .rst          (rst),
        .load         (accept),
        .carry_update (carry_update),
        .new_flags    (new_flags),
        .flags        (stored_flags)
    );

    alu_out_stage #(
        .WIDTH (WIDTH)
    ) u_out (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .result     (result),
        .flags      (new_flags),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_flags  (out_flags),
        .accept     (accept)
    );

endmodule

`default_nettype wire

// File: testbench/tb_alu_unit.sv
`default_nettype none

module tb_alu_unit;

    import alu_pkg::*;

    localparam int WIDTH      = 16;
    localparam int NUM_ROWS   = 29;
    localparam int NUM_RANDOM = 200;
    localparam int MAX_CYCLES = (NUM_ROWS + NUM_RANDOM) * 8 + 100;

    typedef struct packed {
        logic [WIDTH-1:0] result;
        alu_flags_t       flags;
    } expect_t;

    typedef struct packed {
        alu_op_e          op;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        expect_t          exp;
    } row_t;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    alu_op_e          in_op;
    logic [WIDTH-1:0] in_a;
    logic [WIDTH-1:0] in_b;
    logic             out_valid;
    logic             out_ready;
    logic [WIDTH-1:0] out_result;
    alu_flags_t       out_flags;

    expect_t scoreboard [$];     // results still owed by the DUT, oldest first
    logic    model_carry;        // carry the next request will see
    logic    random_ready;       // out_ready follows $urandom when set
    int      cycle_count = 0;

    // columns are opcode, a, b, expected result and expected {carry, zero}
    row_t directed [NUM_ROWS] = '{
        '{op_add,  16'h00ff, 16'h0001, '{16'h0100, '{1'b0, 1'b0}}},
        '{op_add,  16'hffff, 16'h0001, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_and,  16'hf0f0, 16'h0ff0, '{16'h00f0, '{1'b1, 1'b0}}},
        '{op_or,   16'h1234, 16'h4321, '{16'h5335, '{1'b1, 1'b0}}},
        '{op_xor,  16'ha5a5, 16'ha5a5, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_xnor, 16'h1234, 16'h00ff, '{16'hed34, '{1'b1, 1'b0}}},
        '{op_sub,  16'h1000, 16'h0001, '{16'h0fff, '{1'b1, 1'b0}}},
        '{op_and,  16'h5555, 16'haaaa, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_sub,  16'h0001, 16'h0002, '{16'hffff, '{1'b0, 1'b0}}},
        '{op_xor,  16'h00ff, 16'h0f0f, '{16'h0ff0, '{1'b0, 1'b0}}},
        '{op_cmp,  16'h1234, 16'h1234, '{16'hffff, '{1'b0, 1'b0}}},
        '{op_cmp,  16'h1235, 16'h1234, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_cmp,  16'h0100, 16'h0200, '{16'hfeff, '{1'b0, 1'b0}}},
        '{op_sub,  16'h8000, 16'h8000, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_add,  16'hffff, 16'h0001, '{16'h0000, '{1'b1, 1'b1}}},  // 0001_ffff + 1
        '{op_adc,  16'h0001, 16'h0000, '{16'h0002, '{1'b0, 1'b0}}},
        '{op_add,  16'hf000, 16'h2000, '{16'h1000, '{1'b1, 1'b0}}},
        '{op_adc,  16'h8000, 16'h8000, '{16'h0001, '{1'b1, 1'b0}}},
        '{op_sub,  16'h0000, 16'h0001, '{16'hffff, '{1'b0, 1'b0}}},  // 0002_0000 - 1
        '{op_sbc,  16'h0002, 16'h0000, '{16'h0001, '{1'b1, 1'b0}}},
        '{op_sub,  16'h5000, 16'h1000, '{16'h4000, '{1'b1, 1'b0}}},
        '{op_sbc,  16'h3000, 16'h1000, '{16'h2000, '{1'b1, 1'b0}}},
        '{op_shr,  16'hffff, 16'h0011, '{16'h0008, '{1'b1, 1'b0}}},
        '{op_rrc,  16'hffff, 16'h0010, '{16'h8008, '{1'b0, 1'b0}}},
        '{op_rrc,  16'h0000, 16'h0001, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_rrc,  16'h0000, 16'hf0f0, '{16'hf878, '{1'b0, 1'b0}}},
        '{op_shr,  16'h0000, 16'h8001, '{16'h4000, '{1'b1, 1'b0}}},
        '{op_or,   16'h0000, 16'h0000, '{16'h0000, '{1'b1, 1'b1}}},
        '{op_add,  16'h8421, 16'h8421, '{16'h0842, '{1'b1, 1'b0}}}   // a left shift
    };

    alu_unit #(
        .WIDTH (WIDTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_flags  (out_flags)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    task automatic check_result(logic [WIDTH-1:0] got, logic [WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED out_result: got %h, expected %h", got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flags(alu_flags_t got, alu_flags_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED out_flags: got %h, expected %h", got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // expected result from the opcode rules, carry is the flag left by earlier requests
    function automatic expect_t model(alu_op_e op, logic [WIDTH-1:0] a,
                                      logic [WIDTH-1:0] b, logic carry);
        logic [WIDTH:0] sum;
        logic [WIDTH:0] subtrahend;
        expect_t        r;
        r.result      = '0;
        r.flags.carry = carry;  // logic ops keep it
        case (op)
            op_add, op_adc: begin
                sum = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, carry & (op == op_adc)};
                r.result      = sum[WIDTH-1:0];
                r.flags.carry = sum[WIDTH];
            end
            op_sub, op_sbc: begin
                subtrahend    = {1'b0, b} + {{WIDTH{1'b0}}, (op == op_sbc) & ~carry};
                r.result      = a - subtrahend[WIDTH-1:0];
                r.flags.carry = ({1'b0, a} >= subtrahend);  // set when nothing is borrowed
            end
            op_cmp: begin
                r.result      = a - b - WIDTH'(1);
                r.flags.carry = (a > b);
            end
            op_and:  r.result = a & b;
            op_or:   r.result = a | b;
            op_xor:  r.result = a ^ b;
            op_xnor: r.result = ~(a ^ b);
            op_shr: begin
                r.result      = b >> 1;
                r.flags.carry = b[0];
            end
            op_rrc: begin
                r.result      = {carry, b[WIDTH-1:1]};
                r.flags.carry = b[0];
            end
            default: r.result = '0;
        endcase
        r.flags.zero = (r.result == '0);
        return r;
    endfunction

    // one clock cycle, transfers are seen at the falling edge where everything is settled
    task automatic tick(output logic accepted);
        expect_t exp;
        @(negedge clk);
        accepted = in_valid && in_ready;
        if (out_valid && out_ready) begin
            if (scoreboard.size() == 0) begin
                $display("a result came out with no request waiting for it");
                $display("Errors found");
                $fatal(1);
            end else begin
                exp = scoreboard.pop_front();
                check_result(out_result, exp.result);
                check_flags(out_flags, exp.flags);
            end
        end
        @(posedge clk);
        #10;
        out_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    endtask

    task automatic send(alu_op_e op, logic [WIDTH-1:0] a, logic [WIDTH-1:0] b,
                        expect_t exp);
        logic accepted;
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        accepted = 1'b0;
        while (!accepted) begin
            tick(accepted);
        end
        scoreboard.push_back(exp);
        model_carry = exp.flags.carry;
        in_valid = 1'b0;
    endtask

    initial begin
        logic             spare;
        alu_op_e          op;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        void'($urandom(32'hdb4c_8a28));
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_op        = op_add;
        in_a         = '0;
        in_b         = '0;
        out_ready    = 1'b0;  // in_ready then depends on the empty output slot alone
        model_carry  = 1'b0;
        random_ready = 1'b0;

        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            send(directed[i].op, directed[i].a, directed[i].b, directed[i].exp);
        end

        random_ready = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                tick(spare);  // leave a gap between requests now and then
            end
            op = alu_op_e'(4'($urandom_range(0, 10)));
            a  = WIDTH'($urandom);
            b  = WIDTH'($urandom);
            send(op, a, b, model(op, a, b, model_carry));
        end

        while (scoreboard.size() > 0) begin
            tick(spare);
        end
        random_ready = 1'b0;
        repeat (3) tick(spare);  // no extra result may appear once the queue is empty

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/alu_pkg.sv
src/alu_bit_cell.sv
src/alu_slice.sv
src/alu_word.sv
src/alu_op_decode.sv
src/alu_flag_reg.sv
src/alu_out_stage.sv
src/alu_unit.sv
testbench/tb_alu_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_alu_unit \
    --Mdir obj_dir -o tb_alu_unit

output=$(./obj_dir/tb_alu_unit || true)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
